// File: src/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and address helpers
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // Fixed instruction size without compressed encodings
    localparam xlen_t INSTR_BYTES = 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RESOLVE_NONE   = 2'd0,
        RESOLVE_BRANCH = 2'd1,
        RESOLVE_JAL    = 2'd2,
        RESOLVE_JALR   = 2'd3
    } resolve_op_e;

    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'd0,
        FETCH_REQUEST = 2'd1,
        FETCH_RELEASE = 2'd2
    } fetch_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        xlen_t pc;
        xlen_t instr;
        // Address fetch went to after this one
        xlen_t pred_next_pc;
    } fetch_packet_t;

    typedef struct packed {
        logic        valid;
        resolve_op_e op;
        logic        taken;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       imm;
        xlen_t       pred_next_pc;
    } resolve_t;

    typedef struct packed {
        xlen_t addr;
    } imem_req_t;

    typedef struct packed {
        xlen_t data;
    } imem_rsp_t;

    typedef struct packed {
        logic  hit;
        xlen_t target;
    } btb_lookup_t;

    // Real next address of a resolved instruction
    function automatic xlen_t resolve_target(resolve_t r);
        xlen_t target;
        case (r.op)
            RESOLVE_JAL:    target = r.pc + r.imm;
            RESOLVE_JALR:   target = (r.rs1 + r.imm) & ~xlen_t'(1);
            RESOLVE_BRANCH: target = r.taken ? (r.pc + r.imm) : (r.pc + INSTR_BYTES);
            default:        target = r.pc + INSTR_BYTES;
        endcase
        return target;
    endfunction

    // Jumps always leave the sequential path
    function automatic logic resolve_taken(resolve_t r);
        return (r.op == RESOLVE_JAL) || (r.op == RESOLVE_JALR) ||
               ((r.op == RESOLVE_BRANCH) && r.taken);
    endfunction

endpackage

// File: src/pc_stage.sv
module pc_stage
    import fetch_pkg::*;
#(
    parameter xlen_t RESET_PC = 32'h0000_0000
)
(
    input  logic        CLK,
    input  logic        rst,
    input  resolve_t    resolve,
    input  btb_lookup_t btb_lookup,
    input  logic        pc_advance,
    output xlen_t       fetch_pc,
    output xlen_t       pred_next_pc,
    output logic        redirect,
    output xlen_t       redirect_pc,
    output logic        flush_decode,
    output logic        flush_execute
);

    xlen_t pc_q;
    xlen_t actual_next_pc;
    logic  mispredict;

    ////////////////////////////////////////////////////////////////////////////
    // Prediction
    ////////////////////////////////////////////////////////////////////////////

    // Table target on a hit, otherwise fall through
    always_comb
    begin
        if (btb_lookup.hit)
        begin
            pred_next_pc = btb_lookup.target;
        end
        else
        begin
            pred_next_pc = pc_q + INSTR_BYTES;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Misprediction check against the resolved instruction
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        actual_next_pc = resolve_target(resolve);
        mispredict     = resolve.valid && (resolve.op != RESOLVE_NONE) &&
                         (actual_next_pc != resolve.pred_next_pc);
    end

    assign redirect      = mispredict;
    assign redirect_pc   = actual_next_pc;

    // Both later stages hold younger wrong-path work
    assign flush_decode  = mispredict;
    assign flush_execute = mispredict;

    ////////////////////////////////////////////////////////////////////////////
    // PC register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            pc_q <= RESET_PC;
        end
        else if (redirect)
        begin
            pc_q <= redirect_pc;
        end
        else if (pc_advance)
        begin
            pc_q <= pred_next_pc;
        end
    end

    assign fetch_pc = pc_q;

endmodule

// File: src/branch_target_buffer.sv
module branch_target_buffer
    import fetch_pkg::*;
#(
    parameter int unsigned BTB_ENTRIES = 16
)
(
    input  logic        CLK,
    input  logic        rst,
    input  xlen_t       fetch_pc,
    input  resolve_t    resolve,
    output btb_lookup_t btb_lookup
);

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned TAG_W = XLEN - IDX_W - 2;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q [BTB_ENTRIES];
    xlen_t                  target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;
    logic             upd_match;
    logic             upd_write;
    logic             upd_clear;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // Bits 1:0 are always zero for 32-bit instructions
    assign rd_idx = fetch_pc[IDX_W+1:2];
    assign rd_tag = fetch_pc[XLEN-1:IDX_W+2];

    assign btb_lookup.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign btb_lookup.target = target_q[rd_idx];

    ////////////////////////////////////////////////////////////////////////////
    // Training from the execute stage
    ////////////////////////////////////////////////////////////////////////////

    assign upd_idx   = resolve.pc[IDX_W+1:2];
    assign upd_tag   = resolve.pc[XLEN-1:IDX_W+2];
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    assign upd_write = resolve.valid && resolve_taken(resolve);

    // Only drop the entry if it belongs to this branch
    assign upd_clear = resolve.valid && (resolve.op == RESOLVE_BRANCH) &&
                       !resolve.taken && upd_match;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (upd_write)
        begin
            valid_q[upd_idx] <= 1'b1;
        end
        else if (upd_clear)
        begin
            valid_q[upd_idx] <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (upd_write)
        begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= resolve_target(resolve);
        end
    end

endmodule

// File: src/fetch_control.sv
module fetch_control
    import fetch_pkg::*;
#(
    parameter int unsigned BUFFER_DEPTH = 4
)
(
    input  logic          CLK,
    input  logic          rst,
    input  xlen_t         fetch_pc,
    input  xlen_t         pred_next_pc,
    input  logic          redirect,
    input  logic          buffer_full,
    input  logic          imem_ack,
    input  imem_rsp_t     imem_rsp,
    output logic          imem_req,
    output imem_req_t     imem_req_data,
    output logic          pc_advance,
    output logic          push,
    output fetch_packet_t push_packet
);

    // With room for more than one packet a new request starts from release
    localparam bit LAUNCH_ON_RELEASE = (BUFFER_DEPTH > 1);

    fetch_state_e state_q;
    xlen_t        req_pc_q;
    xlen_t        req_pred_q;
    logic         discard_q;
    logic         launch_ok;
    logic         launch;

    ////////////////////////////////////////////////////////////////////////////
    // Launch decision
    ////////////////////////////////////////////////////////////////////////////

    // fetch_pc is stale during a redirect cycle
    assign launch_ok = !buffer_full && !redirect;

    always_comb
    begin
        launch = 1'b0;
        case (state_q)
            FETCH_IDLE:
            begin
                launch = launch_ok;
            end
            FETCH_RELEASE:
            begin
                launch = LAUNCH_ON_RELEASE && !imem_ack && launch_ok;
            end
            default:
            begin
                launch = 1'b0;
            end
        endcase
    end

    // PC moves on as soon as the request goes out
    assign pc_advance = launch;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state_q   <= FETCH_IDLE;
            discard_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                FETCH_IDLE:
                begin
                    if (launch)
                    begin
                        state_q <= FETCH_REQUEST;
                    end
                end
                FETCH_REQUEST:
                begin
                    if (imem_ack)
                    begin
                        state_q <= FETCH_RELEASE;
                    end
                end
                FETCH_RELEASE:
                begin
                    if (launch)
                    begin
                        state_q <= FETCH_REQUEST;
                    end
                    else if (!imem_ack)
                    begin
                        state_q <= FETCH_IDLE;
                    end
                end
                default:
                begin
                    state_q <= FETCH_IDLE;
                end
            endcase

            // Wrong-path transaction still runs to completion
            if (launch)
            begin
                discard_q <= 1'b0;
            end
            else if (redirect && (state_q == FETCH_REQUEST))
            begin
                discard_q <= 1'b1;
            end
        end
    end

    // Request address and prediction held for the whole transaction
    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            req_pc_q   <= fetch_pc;
            req_pred_q <= pred_next_pc;
        end
    end

    assign imem_req           = (state_q == FETCH_REQUEST);
    assign imem_req_data.addr = req_pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // Buffer push
    ////////////////////////////////////////////////////////////////////////////

    assign push = (state_q == FETCH_REQUEST) && imem_ack && !discard_q && !redirect;

    assign push_packet.pc           = req_pc_q;
    assign push_packet.instr        = imem_rsp.data;
    assign push_packet.pred_next_pc = req_pred_q;

endmodule

// File: src/fetch_buffer.sv
module fetch_buffer
    import fetch_pkg::*;
#(
    parameter int unsigned BUFFER_DEPTH = 4
)
(
    input  logic          CLK,
    input  logic          rst,
    input  logic          redirect,
    input  logic          push,
    input  fetch_packet_t push_packet,
    input  logic          packet_take,
    output logic          packet_valid,
    output fetch_packet_t packet,
    output logic          buffer_full
);

    localparam int unsigned PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(BUFFER_DEPTH + 1);

    fetch_packet_t mem_q [BUFFER_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_take;
    logic             do_push;

    assign packet_valid = (count_q != '0);
    assign buffer_full  = (count_q == CNT_W'(BUFFER_DEPTH));
    assign packet       = mem_q[rd_ptr_q];

    assign do_take = packet_valid && packet_take;
    // A full buffer still accepts when decode frees a slot this cycle
    assign do_push = push && (!buffer_full || do_take);

    always_ff @(posedge CLK)
    begin
        if (rst || redirect)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_take)
            begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_take);
        end
    end

    // Packet storage
    always_ff @(posedge CLK)
    begin
        if (do_push && !redirect)
        begin
            mem_q[wr_ptr_q] <= push_packet;
        end
    end

endmodule

// File: src/fetch_front_end.sv
module fetch_front_end
    import fetch_pkg::*;
#(
    parameter xlen_t       RESET_PC     = 32'h0000_1000,
    parameter int unsigned BTB_ENTRIES  = 16,
    parameter int unsigned BUFFER_DEPTH = 4
)
(
    input  logic          CLK,
    input  logic          rst,

    // Instruction memory
    output logic          imem_req,
    output imem_req_t     imem_req_data,
    input  logic          imem_ack,
    input  imem_rsp_t     imem_rsp,

    // Decode
    output logic          packet_valid,
    output fetch_packet_t packet,
    input  logic          packet_take,

    // Execute
    input  resolve_t      resolve,
    output logic          flush_decode,
    output logic          flush_execute
);

    xlen_t         fetch_pc;
    xlen_t         pred_next_pc;
    logic          redirect;
    xlen_t         redirect_pc;
    btb_lookup_t   btb_lookup;
    logic          pc_advance;
    logic          push;
    fetch_packet_t push_packet;
    logic          buffer_full;

    pc_stage #(
        .RESET_PC (RESET_PC)
    ) i_pc_stage (
        .CLK           (CLK),
        .rst           (rst),
        .resolve       (resolve),
        .btb_lookup    (btb_lookup),
        .pc_advance    (pc_advance),
        .fetch_pc      (fetch_pc),
        .pred_next_pc  (pred_next_pc),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .flush_decode  (flush_decode),
        .flush_execute (flush_execute)
    );

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_branch_target_buffer (
        .CLK        (CLK),
        .rst        (rst),
        .fetch_pc   (fetch_pc),
        .resolve    (resolve),
        .btb_lookup (btb_lookup)
    );

    fetch_control #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_fetch_control (
        .CLK           (CLK),
        .rst           (rst),
        .fetch_pc      (fetch_pc),
        .pred_next_pc  (pred_next_pc),
        .redirect      (redirect),
        .buffer_full   (buffer_full),
        .imem_ack      (imem_ack),
        .imem_rsp      (imem_rsp),
        .imem_req      (imem_req),
        .imem_req_data (imem_req_data),
        .pc_advance    (pc_advance),
        .push          (push),
        .push_packet   (push_packet)
    );

    fetch_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_fetch_buffer (
        .CLK          (CLK),
        .rst          (rst),
        .redirect     (redirect),
        .push         (push),
        .push_packet  (push_packet),
        .packet_take  (packet_take),
        .packet_valid (packet_valid),
        .packet       (packet),
        .buffer_full  (buffer_full)
    );

endmodule

// File: sim/tb_imem_model.sv
module tb_imem_model
    import fetch_pkg::*;
#(
    parameter xlen_t PATTERN = 32'h0000_0000,
    parameter int    SEED    = 1
)
(
    input  logic      CLK,
    input  logic      rst,
    input  logic      imem_req,
    input  imem_req_t imem_req_data,
    output logic      imem_ack,
    output imem_rsp_t imem_rsp
);

    int          seed = SEED;
    int unsigned wait_q = 0;
    logic        ack_q = 1'b0;
    xlen_t       data_q = '0;

    assign imem_ack      = ack_q;
    assign imem_rsp.data = data_q;

    // Ack follows req in both directions after 0 to 3 idle cycles
    always @(posedge CLK)
    begin
        if (rst)
        begin
            ack_q  <= 1'b0;
            wait_q <= 0;
        end
        else if (imem_req != ack_q)
        begin
            if (wait_q != 0)
            begin
                wait_q <= wait_q - 1;
            end
            else
            begin
                ack_q  <= imem_req;
                wait_q <= $unsigned($random(seed)) % 4;
                // Data only changes with a rising ack
                if (imem_req)
                begin
                    data_q <= imem_req_data.addr ^ PATTERN;
                end
            end
        end
    end

endmodule

// File: sim/tb_fetch_front_end.sv
module tb_fetch_front_end
    import fetch_pkg::*;
();

    localparam xlen_t       RESET_PC      = 32'h0000_1000;
    localparam int unsigned BTB_ENTRIES   = 16;
    localparam int unsigned BUFFER_DEPTH  = 4;
    localparam xlen_t       INSTR_PATTERN = 32'hA5C3_0F69;
    localparam int          SEED          = 33366;
    localparam int unsigned PACKET_GOAL   = 400;
    localparam int unsigned FIRST_TIMEOUT = 100;
    localparam int unsigned RUN_TIMEOUT   = 20000;

    logic          CLK = 1'b0;
    logic          rst = 1'b1;
    logic          imem_req;
    imem_req_t     imem_req_data;
    logic          imem_ack;
    imem_rsp_t     imem_rsp;
    logic          packet_valid;
    fetch_packet_t packet;
    logic          packet_take = 1'b0;
    resolve_t      resolve = '0;
    logic          flush_decode;
    logic          flush_execute;

    int          seed = SEED;
    xlen_t       expect_pc = RESET_PC;
    xlen_t       trained [xlen_t];
    int unsigned branch_visits = 0;
    int unsigned consumed = 0;
    int unsigned redirect_count = 0;
    int unsigned quiet_count = 0;
    int unsigned clear_count = 0;

    fetch_front_end #(
        .RESET_PC     (RESET_PC),
        .BTB_ENTRIES  (BTB_ENTRIES),
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_fetch_front_end (
        .CLK           (CLK),
        .rst           (rst),
        .imem_req      (imem_req),
        .imem_req_data (imem_req_data),
        .imem_ack      (imem_ack),
        .imem_rsp      (imem_rsp),
        .packet_valid  (packet_valid),
        .packet        (packet),
        .packet_take   (packet_take),
        .resolve       (resolve),
        .flush_decode  (flush_decode),
        .flush_execute (flush_execute)
    );

    tb_imem_model #(
        .PATTERN (INSTR_PATTERN),
        .SEED    (SEED)
    ) i_imem_model (
        .CLK           (CLK),
        .rst           (rst),
        .imem_req      (imem_req),
        .imem_req_data (imem_req_data),
        .imem_ack      (imem_ack),
        .imem_rsp      (imem_rsp)
    );

    always #10 CLK = ~CLK;

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, xlen_t got, xlen_t expected);
        $display("ERROR %s got 0x%08h expected 0x%08h", name, got, expected);
        stop_with_failure();
    endtask

    task automatic fail_run(string reason);
        $display("%s", reason);
        stop_with_failure();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules for control transfers
    ////////////////////////////////////////////////////////////////////////////

    function automatic xlen_t resolved_next_pc(resolve_t r);
        xlen_t sum;
        xlen_t next_pc;
        sum = r.rs1 + r.imm;
        if (r.op == RESOLVE_JALR)
        begin
            next_pc = {sum[31:1], 1'b0};
        end
        else if ((r.op == RESOLVE_JAL) || r.taken)
        begin
            next_pc = r.pc + r.imm;
        end
        else
        begin
            next_pc = r.pc + 32'd4;
        end
        return next_pc;
    endfunction

    function automatic logic transfers_control(resolve_t r);
        return (r.op != RESOLVE_BRANCH) || r.taken;
    endfunction

    function automatic logic expect_flush(resolve_t r);
        return r.valid && (r.op != RESOLVE_NONE) && (resolved_next_pc(r) != r.pred_next_pc);
    endfunction

    // Small looping program inside one BTB span so no two entries alias
    function automatic resolve_t program_resolve(fetch_packet_t p, logic branch_taken);
        resolve_t r;
        r = '0;
        r.pc = p.pc;
        r.pred_next_pc = p.pred_next_pc;
        case (p.pc - RESET_PC)
            32'h08:
            begin
                r.valid = 1'b1;
                r.op    = RESOLVE_BRANCH;
                r.taken = branch_taken;
                r.imm   = 32'h10;
            end
            32'h14:
            begin
                r.valid = 1'b1;
                r.op    = RESOLVE_JALR;
                r.rs1   = RESET_PC + 32'h20;
                r.imm   = 32'h0D;
            end
            32'h30:
            begin
                r.valid = 1'b1;
                r.op    = RESOLVE_JAL;
                r.imm   = -32'sd48;
            end
            default:
            begin
                r.valid = 1'b0;
            end
        endcase
        return r;
    endfunction

    task automatic check_packet(fetch_packet_t p);
        xlen_t pred;
        pred = trained.exists(p.pc) ? trained[p.pc] : p.pc + 32'd4;
        assert (p.pc == expect_pc)
            else report_mismatch("packet.pc", p.pc, expect_pc);
        assert (p.instr == (p.pc ^ INSTR_PATTERN))
            else report_mismatch("packet.instr", p.instr, p.pc ^ INSTR_PATTERN);
        assert (p.pred_next_pc == pred)
            else report_mismatch("packet.pred_next_pc", p.pred_next_pc, pred);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and flush checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge CLK) disable iff (rst)
        $past(imem_req) && !$past(imem_ack) |-> imem_req)
        else fail_run("imem_req dropped before imem_ack was seen high");

    assert property (@(posedge CLK) disable iff (rst)
        !$past(imem_req) && imem_req |-> !$past(imem_ack))
        else fail_run("imem_req rose while imem_ack was still high");

    assert property (@(posedge CLK) disable iff (rst)
        $past(imem_req) && imem_req |-> $stable(imem_req_data.addr))
        else fail_run("imem_req_data.addr changed while imem_req was high");

    assert property (@(posedge CLK) disable iff (rst)
        resolve.valid |-> flush_decode == expect_flush(resolve))
        else report_mismatch("flush_decode", xlen_t'($sampled(flush_decode)),
                             xlen_t'(expect_flush($sampled(resolve))));

    assert property (@(posedge CLK) disable iff (rst)
        resolve.valid |-> flush_execute == expect_flush(resolve))
        else report_mismatch("flush_execute", xlen_t'($sampled(flush_execute)),
                             xlen_t'(expect_flush($sampled(resolve))));

    assert property (@(posedge CLK) disable iff (rst)
        !resolve.valid |-> !flush_decode && !flush_execute)
        else fail_run("Flush raised without a resolved instruction");

    ////////////////////////////////////////////////////////////////////////////
    // Decode and execute models
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge CLK)
    begin
        resolve_t r;
        // Eager and sluggish take phases let the buffer fill up
        if ((consumed % 64) < 32)
        begin
            packet_take <= ($random(seed) & 7) != 0;
        end
        else
        begin
            packet_take <= ($random(seed) & 7) == 0;
        end
        resolve <= '0;
        if (!rst)
        begin
            if (expect_flush(resolve))
            begin
                redirect_count++;
                expect_pc = resolved_next_pc(resolve);
            end
            else if (resolve.valid)
            begin
                quiet_count++;
            end
            // A take during a flush hits a wrong-path packet
            if (!expect_flush(resolve) && packet_valid && packet_take)
            begin
                check_packet(packet);
                expect_pc = packet.pred_next_pc;
                consumed++;
                r = program_resolve(packet, (branch_visits % 3) == 0);
                if (r.valid)
                begin
                    if (r.op == RESOLVE_BRANCH)
                    begin
                        branch_visits++;
                    end
                    if (transfers_control(r))
                    begin
                        trained[r.pc] = resolved_next_pc(r);
                    end
                    else if (trained.exists(r.pc))
                    begin
                        trained.delete(r.pc);
                        clear_count++;
                    end
                    resolve <= r;
                end
            end
        end
    end

    task automatic wait_for_packets(int unsigned goal, int unsigned limit, string reason);
        int unsigned cycles;
        cycles = 0;
        while ((consumed < goal) && (cycles < limit))
        begin
            @(negedge CLK);
            cycles++;
        end
        if (consumed < goal)
        begin
            fail_run(reason);
        end
    endtask

    initial
    begin
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        wait_for_packets(1, FIRST_TIMEOUT, "No packet reached decode after reset");
        wait_for_packets(PACKET_GOAL, RUN_TIMEOUT, "Decode stopped receiving packets");
        if ((redirect_count > 0) && (quiet_count > 0) && (clear_count > 0))
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            fail_run("Run ended before every redirect case was exercised");
        end
    end

endmodule

// File: all.f
src/fetch_pkg.sv
src/pc_stage.sv
src/branch_target_buffer.sv
src/fetch_control.sv
src/fetch_buffer.sv
src/fetch_front_end.sv
sim/tb_imem_model.sv
sim/tb_fetch_front_end.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_front_end -f all.f

output=$(./obj_dir/Vtb_fetch_front_end 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^NO ERRORS$"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
